// ==== include/lza_params.svh ====
// widths, group counts and sentinel for the leading-zero anticipator
// shared by the type packages and the pipeline modules

`ifndef LZA_PARAMS_SVH
`define LZA_PARAMS_SVH

// full datapath and its high/low split
`define LZA_WIDTH        108
`define LZA_HIGH_WIDTH   64
`define LZA_LOW_WIDTH    44

// shift count width, 0..108 fits in 7 bits
`define LZA_RES_WIDTH    7

// count reported when no precode bit is set
`define LZA_NONE         108

// 4-bit groups per half at level 1
`define LZA_HIGH_GROUPS  16
`define LZA_LOW_GROUPS   11

// input edge to output, in clk cycles
`define LZA_LATENCY      2

`endif

// ==== design/lza_op_pkg.sv ====
// operand and result types at the LZA unit boundary

`default_nettype none

package lza_op_pkg;

  `include "lza_params.svh"

  // ------------------------------
  // operand bundle
  // ------------------------------
  // one FMA item: the two aligned terms and the effective operation
  typedef struct packed {
    logic [`LZA_WIDTH-1:0] summand;
    logic [`LZA_WIDTH-1:0] addend;
    // 1 = effective subtraction
    logic                  sub;
  } lza_operands_t;

  // ------------------------------
  // result bundle
  // ------------------------------
  // normalization shift count, LZA_NONE if nothing found
  typedef struct packed {
    logic [`LZA_RES_WIDTH-1:0] count;
  } lza_result_t;

endpackage

`default_nettype wire

// ==== design/lza_tree_pkg.sv ====
// payload and node-output types of the leading-one encoder tree

`default_nettype none

package lza_tree_pkg;

  // ------------------------------
  // per-level encodings
  // ------------------------------
  // level 1: first set bit inside a 4-bit group, 0 = msb
  typedef logic [1:0] lza_idx2_t;

  // level 2: group within a quad, then bit within group
  typedef logic [3:0] lza_enc4_t;

  // level 3: position inside one half, counted from its msb
  typedef logic [5:0] lza_enc6_t;

  // ------------------------------
  // subtree result
  // ------------------------------
  // vld low means the whole half was clear
  // pos is only meaningful with vld set
  typedef struct packed {
    logic      vld;
    lza_enc6_t pos;
  } lza_half_t;

endpackage

`default_nettype wire

// ==== design/lza_precode.sv ====
// carry-term pre-encode of the two operands
// pipeline stage 1 register for the precode vector and its valid

`default_nettype none
`timescale 1ns/1ps

`include "lza_params.svh"

module lza_precode
  import lza_op_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  lza_operands_t         in_op,
  output logic                  pre_valid,
  output logic [`LZA_WIDTH-1:0] pre_vec
);

  localparam int W = `LZA_WIDTH;

  logic [W-1:0] carry_p;
  logic [W-1:0] carry_g;
  logic [W-1:0] carry_d;
  logic [W-1:0] precode;

  // ------------------------------
  // propagate / generate / delete
  // ------------------------------
  assign carry_p = in_op.summand ^ in_op.addend;
  assign carry_g = in_op.summand & in_op.addend;
  assign carry_d = ~(in_op.summand | in_op.addend);

  // ------------------------------
  // precode rule
  // ------------------------------
  // lsb has no lower neighbour, sub decides which term counts
  assign precode[0] =
      carry_p[1] & (carry_g[0] & in_op.sub | carry_d[0])
    | ~carry_p[1] & (carry_d[0] & in_op.sub | carry_g[0]);

  // msb has no upper propagate, split on the operation instead
  assign precode[W-1] = in_op.sub
    ? (carry_g[W-1] & ~carry_d[W-2] | carry_d[W-1] & ~carry_g[W-2])
    : (carry_d[W-1] & ~carry_d[W-2] | ~carry_d[W-1]);

  // middle bits, looking one up and one down
  assign precode[W-2:1] =
      carry_p[W-1:2] & (carry_g[W-2:1] & ~carry_d[W-3:0]
                      | carry_d[W-2:1] & ~carry_g[W-3:0])
    | ~carry_p[W-1:2] & (carry_g[W-2:1] & ~carry_g[W-3:0]
                       | carry_d[W-2:1] & ~carry_d[W-3:0]);

  // ------------------------------
  // stage 1 register
  // ------------------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      pre_valid <= 1'b0;
    else
      pre_valid <= in_valid;
  end

  // vector only moves with a real item
  always_ff @(posedge clk)
  begin
    if (in_valid)
      pre_vec <= precode;
  end

  // nothing may leave stage 1 right after a reset cycle
  property p_pre_valid_after_reset;
    @(posedge clk) !rst_n |=> !pre_valid;
  endproperty
  a_pre_valid_after_reset : assert property (p_pre_valid_after_reset);

endmodule

`default_nettype wire

// ==== design/lza_group_node.sv ====
// leading-valid group compressor, 4:2 or 3:2
// picks the first valid input from the top and appends its payload

`default_nettype none
`timescale 1ns/1ps

module lza_group_node #(
  // number of inputs, up to 4
  parameter int  N         = 4,
  // payload carried up from the level below
  parameter type payload_t = logic [1:0],
  // index followed by payload
  parameter type out_t     = logic [3:0]
) (
  // entry 0 is the most significant group
  input  logic [N-1:0] grp_vld,
  input  payload_t     grp_payload [N],
  output logic         any_vld,
  output out_t         sel
);

  logic [1:0] idx;
  payload_t   pick;

  // ------------------------------
  // priority pick
  // ------------------------------
  // scan bottom up so the topmost valid entry wins
  always_comb
  begin
    any_vld = 1'b0;
    idx     = 2'd0;
    pick    = '0;
    for (int k = N - 1; k >= 0; k--)
    begin
      if (grp_vld[k])
      begin
        any_vld = 1'b1;
        idx     = 2'(k);
        pick    = grp_payload[k];
      end
    end
  end

  // ------------------------------
  // output encoding
  // ------------------------------
  // index goes on top, lower levels keep their order below it
  // with no valid input the value is all zero and ignored upstream
  assign sel = {idx, pick};

endmodule

`default_nettype wire

// ==== design/lza_subtree_encoder.sv ====
// three-level leading-one encoder over one half of the precode vector
// level 1 built in place, levels 2 and 3 from group nodes

`default_nettype none
`timescale 1ns/1ps

module lza_subtree_encoder
  import lza_tree_pkg::*;
#(
  // 4-bit groups in this half, 1..16
  parameter int GROUPS = 16
) (
  input  logic [GROUPS*4-1:0] half_vec,
  output lza_half_t           half
);

  localparam int HW = GROUPS * 4;
  // level 2 node count, last one may be short
  localparam int L2 = (GROUPS + 3) / 4;

  // index 0 is always the topmost group
  logic [GROUPS-1:0] l1_vld;
  lza_idx2_t         l1_idx [GROUPS];
  logic [L2-1:0]     l2_vld;
  lza_enc4_t         l2_enc [L2];
  logic              top_vld;
  lza_enc6_t         top_pos;

  // ------------------------------
  // level 1, one per nibble
  // ------------------------------
  for (genvar g = 0; g < GROUPS; g++)
  begin : g_l1
    logic [3:0] nib;

    assign nib       = half_vec[HW-1-4*g -: 4];
    assign l1_vld[g] = |nib;
    // first set bit counted from the nibble msb
    assign l1_idx[g] = nib[3] ? 2'd0 :
                       nib[2] ? 2'd1 :
                       nib[1] ? 2'd2 : 2'd3;
  end

  // ------------------------------
  // level 2, groups of four
  // ------------------------------
  for (genvar j = 0; j < L2; j++)
  begin : g_l2
    // 3:2 node at the tail when GROUPS is not a multiple of four
    localparam int NJ = (GROUPS - 4 * j > 4) ? 4 : GROUPS - 4 * j;

    lza_idx2_t node_idx [NJ];

    for (genvar k = 0; k < NJ; k++)
    begin : g_in
      assign node_idx[k] = l1_idx[4*j+k];
    end

    lza_group_node #(
      .N         (NJ),
      .payload_t (lza_idx2_t),
      .out_t     (lza_enc4_t)
    ) u_node (
      .grp_vld     (l1_vld[4*j +: NJ]),
      .grp_payload (node_idx),
      .any_vld     (l2_vld[j]),
      .sel         (l2_enc[j])
    );
  end

  // ------------------------------
  // level 3, single node
  // ------------------------------
  // 4:2 for the high half, 3:2 for the low half
  lza_group_node #(
    .N         (L2),
    .payload_t (lza_enc4_t),
    .out_t     (lza_enc6_t)
  ) u_top (
    .grp_vld     (l2_vld),
    .grp_payload (l2_enc),
    .any_vld     (top_vld),
    .sel         (top_pos)
  );

  // pos = group * 4 + bit, both from the half msb
  assign half = '{vld: top_vld, pos: top_pos};

endmodule

`default_nettype wire

// ==== design/lza_result_merge.sv ====
// high/low merge of the two subtree results with sentinel insertion
// pipeline stage 2 register for the shift count

`default_nettype none
`timescale 1ns/1ps

`include "lza_params.svh"

module lza_result_merge
  import lza_op_pkg::*;
  import lza_tree_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        pre_valid,
  input  lza_half_t   high,
  input  lza_half_t   low,
  output logic        out_valid,
  output lza_result_t out_res
);

  lza_result_t next_res;

  // ------------------------------
  // merge
  // ------------------------------
  // high half wins over the low half
  // low positions sit 64 further down
  always_comb
  begin
    if (high.vld)
      next_res.count = {1'b0, high.pos};
    else if (low.vld)
      next_res.count = {1'b1, low.pos};
    else
      next_res.count = `LZA_RES_WIDTH'(`LZA_NONE);
  end

  // ------------------------------
  // stage 2 register
  // ------------------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      out_valid <= 1'b0;
    else
      out_valid <= pre_valid;
  end

  always_ff @(posedge clk)
  begin
    if (pre_valid)
      out_res <= next_res;
  end

  // a valid count stays within 0..108
  property p_count_range;
    @(posedge clk) disable iff (!rst_n)
      out_valid |-> out_res.count <= `LZA_NONE;
  endproperty
  a_count_range : assert property (p_count_range);

endmodule

`default_nettype wire

// ==== design/lza_unit.sv ====
// top of the pipelined leading-zero anticipator
// precode, high and low encoder subtrees, result merge

`default_nettype none
`timescale 1ns/1ps

`include "lza_params.svh"

module lza_unit
  import lza_op_pkg::*;
  import lza_tree_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          in_valid,
  input  lza_operands_t in_op,
  output logic          out_valid,
  output lza_result_t   out_res
);

  logic                  pre_valid;
  logic [`LZA_WIDTH-1:0] pre_vec;
  lza_half_t             high_half;
  lza_half_t             low_half;

  // ------------------------------
  // stage 1
  // ------------------------------
  lza_precode u_precode (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_op     (in_op),
    .pre_valid (pre_valid),
    .pre_vec   (pre_vec)
  );

  // ------------------------------
  // encoder tree, combinational
  // ------------------------------
  // bits 107..44
  lza_subtree_encoder #(
    .GROUPS (`LZA_HIGH_GROUPS)
  ) u_high_tree (
    .half_vec (pre_vec[`LZA_WIDTH-1 -: `LZA_HIGH_WIDTH]),
    .half     (high_half)
  );

  // bits 43..0
  lza_subtree_encoder #(
    .GROUPS (`LZA_LOW_GROUPS)
  ) u_low_tree (
    .half_vec (pre_vec[`LZA_LOW_WIDTH-1:0]),
    .half     (low_half)
  );

  // ------------------------------
  // stage 2
  // ------------------------------
  lza_result_merge u_merge (
    .clk       (clk),
    .rst_n     (rst_n),
    .pre_valid (pre_valid),
    .high      (high_half),
    .low       (low_half),
    .out_valid (out_valid),
    .out_res   (out_res)
  );

endmodule

`default_nettype wire

// ==== verif/lza_tb_checks.sv ====
// rule-based reference model of the LZA and its checking assertions
// two-deep expected-value pipe matching the DUT latency

`default_nettype none
`timescale 1ns/1ps

`include "lza_params.svh"

module lza_tb_checks
  import lza_op_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          in_valid,
  input  lza_operands_t in_op,
  input  logic          out_valid,
  input  lza_result_t   out_res,
  output int            errors,
  output int            checked
);

  localparam int W = `LZA_WIDTH;

  // one expected item, acc marks an add whose sum stays below 2^107
  typedef struct packed {
    logic                      vld;
    logic                      acc;
    logic [`LZA_RES_WIDTH-1:0] count;
    logic [`LZA_RES_WIDTH-1:0] lzc;
  } exp_item_t;

  exp_item_t exp_q [2];
  exp_item_t in_item;
  int        error_cnt = 0;
  int        checked_cnt = 0;

  // ------------------------------
  // reference model
  // ------------------------------
  // precode straight from the p/g/d rule, one bit at a time
  function automatic logic [W-1:0] precode_ref(input lza_operands_t op);
    logic [W-1:0] p;
    logic [W-1:0] g;
    logic [W-1:0] d;
    logic [W-1:0] v;
    p = op.summand ^ op.addend;
    g = op.summand & op.addend;
    d = ~(op.summand | op.addend);
    v[0] = p[1] ? (g[0] && op.sub || d[0]) : (d[0] && op.sub || g[0]);
    for (int i = 1; i < W - 1; i++)
    begin
      if (p[i+1])
        v[i] = g[i] && !d[i-1] || d[i] && !g[i-1];
      else
        v[i] = g[i] && !g[i-1] || d[i] && !d[i-1];
    end
    if (op.sub)
      v[W-1] = g[W-1] && !d[W-2] || d[W-1] && !g[W-2];
    else
      v[W-1] = d[W-1] && !d[W-2] || !d[W-1];
    return v;
  endfunction

  // 107 minus highest set index, sentinel when clear
  function automatic logic [`LZA_RES_WIDTH-1:0] lead_zero_count(input logic [W-1:0] v);
    logic [`LZA_RES_WIDTH-1:0] c;
    c = `LZA_RES_WIDTH'(`LZA_NONE);
    for (int i = 0; i < W; i++)
    begin
      if (v[i])
        c = `LZA_RES_WIDTH'(W - 1 - i);
    end
    return c;
  endfunction

  function automatic exp_item_t predict(input lza_operands_t op, input logic vld);
    exp_item_t   it;
    logic [W:0]  sum;
    sum = {1'b0, op.summand} + {1'b0, op.addend};
    it.vld   = vld;
    it.count = lead_zero_count(precode_ref(op));
    it.lzc   = lead_zero_count(sum[W-1:0]);
    it.acc   = !op.sub && sum[W:W-1] == 2'b00;
    return it;
  endfunction

  always_comb
    in_item = predict(in_op, in_valid);

  // ------------------------------
  // expected-value pipe
  // ------------------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      exp_q[0] <= '0;
      exp_q[1] <= '0;
    end
    else
    begin
      exp_q[0] <= in_item;
      exp_q[1] <= exp_q[0];
      if (out_valid)
        checked_cnt <= checked_cnt + 1;
    end
  end

  assign errors  = error_cnt;
  assign checked = checked_cnt;

  // ------------------------------
  // assertions
  // ------------------------------
  a_reset_quiet : assert property (@(posedge clk) !rst_n |=> !out_valid)
    else
    begin
      $display("out_valid was high right after a reset cycle");
      error_cnt++;
    end

  // gaps and latency, valid pattern delayed by exactly 2
  a_valid_timing : assert property (@(posedge clk) disable iff (!rst_n)
    out_valid == exp_q[1].vld)
    else
    begin
      $display("Mismatch out_valid: got %h, expected %h", $sampled(out_valid),
               $sampled(exp_q[1].vld));
      error_cnt++;
    end

  a_count : assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> out_res.count == exp_q[1].count)
    else
    begin
      $display("Mismatch out_res.count: got %h, expected %h", $sampled(out_res.count),
               $sampled(exp_q[1].count));
      error_cnt++;
    end

  // add without overflow past bit 106, off by one at most
  a_accuracy : assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && exp_q[1].acc |->
      {1'b0, out_res.count} + 8'd1 >= {1'b0, exp_q[1].lzc} &&
      {1'b0, exp_q[1].lzc} + 8'd1 >= {1'b0, out_res.count})
    else
    begin
      $display("anticipated count %0d is more than one away from true count %0d",
               $sampled(out_res.count), $sampled(exp_q[1].lzc));
      error_cnt++;
    end

endmodule

`default_nettype wire

// ==== verif/lza_tb.sv ====
// testbench top for the LZA unit
// clock, reset, stimulus per test, watchdog and final report

`default_nettype none
`timescale 1ns/1ps

`include "lza_params.svh"

module lza_tb
  import lza_op_pkg::*;
();

  localparam int W         = `LZA_WIDTH;
  localparam int NUM_TESTS = 6;
  localparam int MAX_ITEMS = 500;

  logic          clk;
  logic          rst_n;
  logic          in_valid;
  lza_operands_t in_op;
  logic          out_valid;
  lza_result_t   out_res;
  int            errors;
  int            checked;
  int            seed;
  int            tests_failed = 0;
  int            err_mark;
  int            chk_mark;
  int            sh;

  lza_unit dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_op     (in_op),
    .out_valid (out_valid),
    .out_res   (out_res)
  );

  lza_tb_checks chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_op     (in_op),
    .out_valid (out_valid),
    .out_res   (out_res),
    .errors    (errors),
    .checked   (checked)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  function automatic logic [W-1:0] rand_operand();
    logic [127:0] r;
    r = {$random(seed), $random(seed), $random(seed), $random(seed)};
    return r[W-1:0];
  endfunction

  // starts on a falling edge and returns on the next one
  task automatic send(input logic [W-1:0] a, input logic [W-1:0] b, input logic sub);
    in_valid      = 1'b1;
    in_op.summand = a;
    in_op.addend  = b;
    in_op.sub     = sub;
    @(negedge clk);
  endtask

  task automatic idle(input int n);
    in_valid = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  task automatic start_test();
    err_mark = errors;
    chk_mark = checked;
  endtask

  // drain both pipeline stages before counting
  task automatic end_test(input string name);
    idle(`LZA_LATENCY + 1);
    if (errors != err_mark)
      tests_failed++;
    $display("test %s: %0d results checked, %0d errors", name, checked - chk_mark,
             errors - err_mark);
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial
  begin
    seed     = 32'h5ed2;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_op    = '0;
    start_test();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    idle(4);
    end_test("reset");

    start_test();
    repeat (3) send('0, '0, 1'b0);
    end_test("empty");

    // all-propagate under sub leaves the precode clear
    // and one delete bit then marks position i
    start_test();
    for (int i = 0; i < W; i++)
      send(~({{(W-1){1'b0}}, 1'b1} << i), '0, 1'b1);
    // a single summand bit under add marks the bit above it
    for (int i = 1; i < W; i++)
      send({{(W-1){1'b0}}, 1'b1} << (i - 1), '0, 1'b0);
    end_test("sweep");

    start_test();
    for (int k = 0; k < MAX_ITEMS; k++)
      send(rand_operand(), rand_operand(), k[0]);
    end_test("random");

    start_test();
    for (int k = 0; k < 200; k++)
    begin
      if (($random(seed) & 3) == 0)
        idle(1 + ($random(seed) & 1));
      send(rand_operand(), rand_operand(), 1'($random(seed)));
    end
    end_test("pipeline");

    // both operands below 2^106 keep the sum below 2^107
    start_test();
    for (int k = 0; k < 300; k++)
    begin
      sh = 2 + ($unsigned($random(seed)) % 104);
      send(rand_operand() >> sh, rand_operand() >> (sh + ($random(seed) & 3)), 1'b0);
    end
    end_test("accuracy");

    $display("tests run %0d, failed %0d, check errors %0d", NUM_TESTS, tests_failed,
             errors);
    if (tests_failed == 0 && errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  // watchdog bounded by tests times items per test
  initial
  begin
    #(NUM_TESTS * MAX_ITEMS * 10 + 2000);
    $display("timeout: the test sequence did not complete in time");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+include
design/lza_op_pkg.sv
design/lza_tree_pkg.sv
design/lza_precode.sv
design/lza_group_node.sv
design/lza_subtree_encoder.sv
design/lza_result_merge.sv
design/lza_unit.sv
verif/lza_tb_checks.sv
verif/lza_tb.sv

// ==== Makefile ====
# Verilator build and run for the LZA testbench

VERILATOR ?= verilator
TOP       ?= lza_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing
PASS_MSG  ?= ALL TESTS PASSED

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv verif/*.sv include/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
